// ==== filelist.f ====
common/sifhPkg.sv
common/axiLitePkg.sv
common/histRamIf.sv
histogram/histRam.sv
histogram/peakFinder.sv
histogram/sifhFsm.sv
hdl/sifhRegs.sv
hdl/sifhTop.sv
dv/sifhTop_checker.sv
dv/sifhTb.sv

// ==== Makefile ====
TOP := sifhTb

.PHONY: sim clean

sim:
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) -f filelist.f
	./obj_dir/V$(TOP) +verilator+error+limit+1000 | tee sim.log
	grep -q "Test completed successfully" sim.log

clean:
	rm -rf obj_dir sim.log

// ==== dv/sifhTb.sv ====
module sifhTb import sifhPkg::*, axiLitePkg::*; ();
    timeunit 1ns;
    timeprecision 100ps;

    localparam int frameBudget = 3000;                  // samples, gaps, stalls and one 256 bin scan
    localparam int maxCycles = 6 * frameBudget + 2000;  // five frames plus the reset clear pass

    logic clk = 1'b0;
    logic rstN;
    logic sampleValid;
    logic [pixBits-1:0] samplePixel;
    logic [Np-1:0] sampleCode;
    logic sampleReady;
    logic [axiAddrBits-1:0] awaddr;
    logic awvalid;
    logic awready;
    logic [axiDataBits-1:0] wdata;
    logic [axiStrbBits-1:0] wstrb;
    logic wvalid;
    logic wready;
    logic [1:0] bresp;
    logic bvalid;
    logic bready;
    logic [axiAddrBits-1:0] araddr;
    logic arvalid;
    logic arready;
    logic [axiDataBits-1:0] rdata;
    logic [1:0] rresp;
    logic rvalid;
    logic rready;

    int model [PIXEL_NUM_PER_RAM][1 << Nb];          // counts of the open frame
    logic [axiDataBits-1:0] expPeak [PIXEL_NUM_PER_RAM];   // peaks of the closed frame
    int errors = 0;
    int cycles = 0;

    sifhTop DUT (.*);

    always #2 clk = ~clk;   // 4 ns period

    always @(posedge clk) begin
        cycles++;
        if (cycles >= maxCycles) begin
            $display("timeout: run stopped after %0d cycles without finishing", cycles);
            $display("Test failed");
            $finish;
        end
    end

    task automatic compareValue(input string name, input logic [31:0] expected,
                                input logic [31:0] actual);
        assert (actual == expected) else begin
            $display("[FAIL] %s expected %08h actual %08h", name, expected, actual);
            errors++;
        end
    endtask

    function automatic void clearModel();
        foreach (model[p, b]) model[p][b] = 0;
    endfunction

    // mode bin of one pixel, packed as the PEAK register
    function automatic logic [31:0] expectedPeak(input int pix);
        int bestBin;
        int bestCount;
        logic [31:0] word;
        bestBin = 0;
        bestCount = model[pix][0];
        for (int b = 1; b < (1 << Nb); b++) begin
            if (model[pix][b] > bestCount) begin   // strictly greater, a tie keeps the lower bin
                bestBin = b;
                bestCount = model[pix][b];
            end
        end
        word = '0;
        word[21:16] = bestBin[5:0];
        word[7:0] = bestCount[7:0];
        return word;
    endfunction

    task automatic sendSample(input int pix, input int code, input int gap);
        int bin;
        bin = code >> (Np - Nb);   // top bits of the code
        sampleValid = 1'b1;
        samplePixel = pixBits'(pix);
        sampleCode = Np'(code);
        while (!sampleReady) begin   // held through a scan
            @(posedge clk);
            #1;
        end
        @(posedge clk);   // transfer edge
        #1;
        if (model[pix][bin] < 255) model[pix][bin]++;   // saturating count
        if (gap > 0) begin
            sampleValid = 1'b0;
            repeat (gap) @(posedge clk);
            #1;
        end
    endtask

    task automatic axiWrite(input logic [7:0] addr, input logic [31:0] data,
                            output logic [1:0] resp);
        logic awHit;
        logic wHit;
        int stall;
        awaddr = addr;
        awvalid = 1'b1;
        wdata = data;
        wstrb = '1;
        wvalid = 1'b1;
        while (awvalid || wvalid) begin
            awHit = awvalid && awready;
            wHit = wvalid && wready;
            @(posedge clk);
            #1;
            if (awHit) awvalid = 1'b0;
            if (wHit) wvalid = 1'b0;
        end
        stall = $urandom_range(0, 3);   // bready held back
        repeat (stall) @(posedge clk);
        if (stall > 0) #1;
        bready = 1'b1;
        while (!bvalid) begin
            @(posedge clk);
            #1;
        end
        resp = bresp;
        @(posedge clk);
        #1;
        bready = 1'b0;
    endtask

    task automatic axiRead(input logic [7:0] addr, output logic [31:0] data,
                           output logic [1:0] resp);
        int stall;
        araddr = addr;
        arvalid = 1'b1;
        while (!arready) begin
            @(posedge clk);
            #1;
        end
        @(posedge clk);   // address taken
        #1;
        arvalid = 1'b0;
        stall = $urandom_range(0, 3);   // rready held back
        repeat (stall) @(posedge clk);
        if (stall > 0) #1;
        rready = 1'b1;
        while (!rvalid) begin
            @(posedge clk);
            #1;
        end
        data = rdata;
        resp = rresp;
        @(posedge clk);
        #1;
        rready = 1'b0;
    endtask

    // freeze expected peaks, start a fresh model, close the frame
    task automatic requestClose();
        logic [1:0] resp;
        for (int p = 0; p < PIXEL_NUM_PER_RAM; p++) expPeak[p] = expectedPeak(p);
        clearModel();
        axiWrite(CTRL_OFFSET, 32'h1, resp);
        compareValue("close resp", 32'(RESP_OKAY), 32'(resp));
    endtask

    task automatic readPeaks(input string name);
        logic [31:0] data;
        logic [1:0] resp;
        data = '0;
        while (!data[1]) begin   // peaksValid
            axiRead(STATUS_OFFSET, data, resp);
            compareValue({name, " status resp"}, 32'(RESP_OKAY), 32'(resp));
        end
        for (int p = 0; p < PIXEL_NUM_PER_RAM; p++) begin
            axiRead(PEAK_BASE + 8'(4 * p), data, resp);
            compareValue({name, " peak resp"}, 32'(RESP_OKAY), 32'(resp));
            compareValue($sformatf("%s pixel %0d", name, p), expPeak[p], data);
        end
    endtask

    initial begin
        logic [31:0] data;
        logic [1:0] resp;
        void'($urandom(19162));
        rstN = 1'b0;
        sampleValid = 1'b0;
        samplePixel = '0;
        sampleCode = '0;
        awaddr = '0;
        awvalid = 1'b0;
        wdata = '0;
        wstrb = '0;
        wvalid = 1'b0;
        bready = 1'b0;
        araddr = '0;
        arvalid = 1'b0;
        rready = 1'b0;
        clearModel();
        repeat (2) @(posedge clk);
        #1 rstN = 1'b1;

        // random pixels, codes and idle gaps
        repeat (200) begin
            sendSample($urandom_range(0, 3), $urandom_range(0, 1023), $urandom_range(0, 2));
        end
        sampleValid = 1'b0;   // already at 1 ns past the last transfer
        requestClose();
        readPeaks("basic");

        // pixel 1 ties bins 12 and 40, pixel 3 left empty
        for (int i = 0; i < 6; i++) begin
            sendSample(1, 40 << 4, 1);
            sendSample(1, (12 << 4) + i, 0);
        end
        sendSample(0, 5 << 4, 0);
        sendSample(2, 50 << 4, 1);
        requestClose();
        readPeaks("tie");

        // same bin every cycle, then an A B A B pattern
        repeat (20) sendSample(2, 7 << 4, 0);
        repeat (4) begin
            sendSample(0, 1 << 4, 0);
            sendSample(0, 2 << 4, 0);
        end
        sampleValid = 1'b0;
        requestClose();
        readPeaks("forward");

        // 300 hits in one bin, next frame's first sample waits out the scan
        repeat (300) sendSample(3, 10'h3ff, 0);
        sendSample(1, 20 << 4, 1);
        requestClose();
        sendSample(2, 33 << 4, 1);
        readPeaks("saturate");
        repeat (40) sendSample($urandom_range(0, 3), $urandom_range(0, 511), $urandom_range(0, 1));
        sampleValid = 1'b0;
        requestClose();
        readPeaks("clear");

        // unmapped read, write to a read-only register
        axiRead(8'h40, data, resp);
        compareValue("unmapped resp", 32'(RESP_SLVERR), 32'(resp));
        compareValue("unmapped data", 32'h0, data);
        axiWrite(STATUS_OFFSET, 32'h3, resp);
        compareValue("status write resp", 32'(RESP_SLVERR), 32'(resp));

        repeat (4) @(posedge clk);
        $display("errors: %0d value, %0d protocol", errors, DUT.protocolCheck.failCount);
        if (errors == 0 && DUT.protocolCheck.failCount == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

// ==== dv/sifhTop_checker.sv ====
module sifhTop_checker import sifhPkg::*, axiLitePkg::*; (
    input logic clk,
    input logic rstN,
    input logic sampleValid,
    input logic sampleReady,
    input logic [1:0] bresp,
    input logic bvalid,
    input logic bready,
    input logic [axiDataBits-1:0] rdata,
    input logic [1:0] rresp,
    input logic rvalid,
    input logic rready,
    input logic closeFrame,
    input logic histWen,
    input countT histWdata
);
    timeunit 1ns;
    timeprecision 100ps;

    int failCount = 0;   // number of failed assertions

    // nothing pending straight out of reset
    resetQuiet: assert property (@(posedge clk) !rstN |=> !bvalid && !rvalid)
        else begin
            $error("bvalid or rvalid high on the first cycle after reset");
            failCount++;
        end

    // write response waits for bready, unchanged
    bHold: assert property (@(posedge clk) disable iff (!rstN)
        bvalid && !bready |=> bvalid && $stable(bresp))
        else begin
            $error("write response dropped or changed before bready");
            failCount++;
        end

    // read data waits for rready, unchanged
    rHold: assert property (@(posedge clk) disable iff (!rstN)
        rvalid && !rready |=> rvalid && $stable(rresp) && $stable(rdata))
        else begin
            $error("read response dropped or changed before rready");
            failCount++;
        end

    // a sample held off by sampleReady never reaches the histogram
    // only scan writes, all zero, may follow a not ready cycle
    noAcceptWhenBusy: assert property (@(posedge clk) disable iff (!rstN)
        sampleValid && !sampleReady |=> !(histWen && (histWdata != '0)))
        else begin
            $error("histogram count written for a sample offered while sampleReady was low");
            failCount++;
        end

    // stream closes one cycle after the accepted CTRL write
    closeStopsStream: assert property (@(posedge clk) disable iff (!rstN)
        closeFrame |=> !sampleReady)
        else begin
            $error("sampleReady still high the cycle after closeFrame");
            failCount++;
        end

endmodule

bind sifhTop sifhTop_checker protocolCheck (
    .clk(clk), .rstN(rstN),
    .sampleValid(sampleValid), .sampleReady(sampleReady),
    .bresp(bresp), .bvalid(bvalid), .bready(bready),
    .rdata(rdata), .rresp(rresp), .rvalid(rvalid), .rready(rready),
    .closeFrame(closeFrame),
    .histWen(histIf.wEnable), .histWdata(histIf.wdata)
);

// ==== hdl/sifhTop.sv ====
module sifhTop import sifhPkg::*, axiLitePkg::*; (
    input  logic clk,
    input  logic rstN,
    // sample stream
    input  logic sampleValid,
    input  logic [pixBits-1:0] samplePixel,
    input  logic [Np-1:0] sampleCode,
    output logic sampleReady,
    // AXI4-Lite slave
    input  logic [axiAddrBits-1:0] awaddr,
    input  logic awvalid,
    output logic awready,
    input  logic [axiDataBits-1:0] wdata,
    input  logic [axiStrbBits-1:0] wstrb,
    input  logic wvalid,
    output logic wready,
    output logic [1:0] bresp,
    output logic bvalid,
    input  logic bready,
    input  logic [axiAddrBits-1:0] araddr,
    input  logic arvalid,
    output logic arready,
    output logic [axiDataBits-1:0] rdata,
    output logic [1:0] rresp,
    output logic rvalid,
    input  logic rready
);

    logic closeFrame;
    logic scanBusy;
    logic scanDone;

    histRamIf #(.addrWidth(addrBits), .wordT(countT)) histIf ();   // counts, {pixel, bin}
    histRamIf #(.addrWidth(pixBits), .wordT(peakT)) peakIf ();     // one result per pixel

    sifhRegs sifhRegs (
        .clk(clk), .rstN(rstN),
        .awaddr(awaddr), .awvalid(awvalid), .awready(awready),
        .wdata(wdata), .wstrb(wstrb), .wvalid(wvalid), .wready(wready),
        .bresp(bresp), .bvalid(bvalid), .bready(bready),
        .araddr(araddr), .arvalid(arvalid), .arready(arready),
        .rdata(rdata), .rresp(rresp), .rvalid(rvalid), .rready(rready),
        .closeFrame(closeFrame), .scanBusy(scanBusy), .scanDone(scanDone),
        .peak(peakIf)      // read side
    );

    sifhFsm sifhFsm (
        .clk(clk), .rstN(rstN),
        .sampleValid(sampleValid), .samplePixel(samplePixel),
        .sampleCode(sampleCode), .sampleReady(sampleReady),
        .closeFrame(closeFrame), .scanBusy(scanBusy), .scanDone(scanDone),
        .hist(histIf),
        .peak(peakIf)      // write side, from the scan
    );

    histRam #(.wordT(countT), .depth(histDepth)) histRam (.clk(clk), .ram(histIf));
    histRam #(.wordT(peakT), .depth(PIXEL_NUM_PER_RAM)) peakRam (.clk(clk), .ram(peakIf));

endmodule

// ==== hdl/sifhRegs.sv ====
module sifhRegs import sifhPkg::*, axiLitePkg::*; (
    input  logic clk,
    input  logic rstN,
    input  logic [axiAddrBits-1:0] awaddr,
    input  logic awvalid,
    output logic awready,
    input  logic [axiDataBits-1:0] wdata,
    input  logic [axiStrbBits-1:0] wstrb,
    input  logic wvalid,
    output logic wready,
    output logic [1:0] bresp,
    output logic bvalid,
    input  logic bready,
    input  logic [axiAddrBits-1:0] araddr,
    input  logic arvalid,
    output logic arready,
    output logic [axiDataBits-1:0] rdata,
    output logic [1:0] rresp,
    output logic rvalid,
    input  logic rready,
    output logic closeFrame,
    input  logic scanBusy,
    input  logic scanDone,
    histRamIf.fsmRd peak
);

    typedef enum logic [1:0] {RD_ERR, RD_STATUS, RD_PEAK} rdKindT;

    logic awHeld;                      // address phase latched
    logic wHeld;                       // data phase latched
    logic [axiAddrBits-1:0] awAddrQ;
    logic [axiDataBits-1:0] wDataQ;
    logic [axiStrbBits-1:0] wStrbQ;
    logic doWrite;
    logic wrIsCtrl;

    logic rdAccept;
    logic rdIsStatus;
    logic rdIsPeak;
    rdKindT rdKind;
    logic [axiDataBits-1:0] statusWord;
    logic [axiDataBits-1:0] statusQ;
    peakT peakWord;
    logic peaksValid;

    // write side, one transaction at a time
    assign awready = !awHeld && !bvalid;
    assign wready = !wHeld && !bvalid;
    assign doWrite = awHeld && wHeld && !bvalid;
    assign wrIsCtrl = (awAddrQ == CTRL_OFFSET);
    // ignored while a scan runs, still answered with OKAY
    assign closeFrame = doWrite && wrIsCtrl && wStrbQ[0] && wDataQ[0] && !scanBusy;

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            awHeld <= 1'b0;
            wHeld <= 1'b0;
            bvalid <= 1'b0;
            bresp <= RESP_OKAY;
        end else begin
            if (awvalid && awready) awHeld <= 1'b1;
            if (wvalid && wready) wHeld <= 1'b1;
            if (doWrite) begin
                awHeld <= 1'b0;
                wHeld <= 1'b0;
                bvalid <= 1'b1;                  // response one cycle after both held
                bresp <= wrIsCtrl ? RESP_OKAY : RESP_SLVERR;
            end else if (bvalid && bready) begin
                bvalid <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (awvalid && awready) awAddrQ <= awaddr;
        if (wvalid && wready) begin
            wDataQ <= wdata;
            wStrbQ <= wstrb;
        end
    end

    // Status flag, set by the scan and dropped when the next one is requested
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            peaksValid <= 1'b0;
        end else if (closeFrame) begin
            peaksValid <= 1'b0;
        end else if (scanDone) begin
            peaksValid <= 1'b1;
        end
    end

    // read side decode
    assign arready = !rvalid;
    assign rdAccept = arvalid && arready;
    assign rdIsStatus = (araddr == STATUS_OFFSET);
    assign rdIsPeak = (araddr >= PEAK_BASE) &&
                      (araddr < PEAK_BASE + 8'(4 * PIXEL_NUM_PER_RAM)) &&
                      (araddr[1:0] == 2'b00);   // word aligned only

    assign peak.raddr = araddr[2 +: pixBits];   // one word per pixel
    assign peak.rEnable = rdAccept && rdIsPeak;

    always_comb begin
        statusWord = '0;
        statusWord[STATUS_SCAN_BUSY] = scanBusy;
        statusWord[STATUS_PEAKS_VALID] = peaksValid;
    end

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            rvalid <= 1'b0;
            rresp <= RESP_OKAY;
            rdKind <= RD_ERR;
        end else if (rdAccept) begin
            rvalid <= 1'b1;
            rresp <= (rdIsStatus || rdIsPeak) ? RESP_OKAY : RESP_SLVERR;
            rdKind <= rdIsStatus ? RD_STATUS : (rdIsPeak ? RD_PEAK : RD_ERR);
        end else if (rvalid && rready) begin
            rvalid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (rdAccept) statusQ <= statusWord;   // snapshot, stable while rvalid waits
    end

    // result RAM word holds until the next peak read
    assign peakWord = peak.rdata;

    always_comb begin
        rdata = '0;
        case (rdKind)
            RD_STATUS: rdata = statusQ;
            RD_PEAK: begin
                rdata[PEAK_BIN_LSB +: Nb] = peakWord.bin;
                rdata[PEAK_COUNT_LSB +: peakMax] = peakWord.count;
            end
            default: rdata = '0;               // SLVERR carries zero
        endcase
    end

endmodule

// ==== histogram/sifhFsm.sv ====
module sifhFsm import sifhPkg::*; (
    input  logic clk,
    input  logic rstN,
    input  logic sampleValid,
    input  logic [pixBits-1:0] samplePixel,
    input  logic [Np-1:0] sampleCode,
    output logic sampleReady,
    input  logic closeFrame,     // one cycle pulse from the register block
    output logic scanBusy,
    output logic scanDone,       // one cycle pulse at the end of a frame scan
    histRamIf.fsm hist,
    histRamIf.fsmWr peak
);

    // INIT and CLEAR form the zeroing pass after reset
    typedef enum logic [2:0] {INIT, CLEAR, ACCUM, DRAIN, SCAN} modeT;

    modeT mode;

    logic accept;
    logic [addrBits-1:0] sampleAddr;
    logic s1Valid;                 // stage two holds a sample
    logic [addrBits-1:0] s1Addr;
    logic fwdHit;
    countT fwdData;
    countT curCount;
    countT incCount;

    logic scanMode;
    logic pfStart;
    logic pfBusy;
    logic pfDone;
    logic [addrBits-1:0] scanRaddr;
    logic [addrBits-1:0] scanWaddr;
    logic scanWen;

    assign sampleReady = (mode == ACCUM);
    assign accept = sampleValid && sampleReady;
    assign sampleAddr = {samplePixel, sampleCode[Np-1 -: Nb]};   // bin = code MSBs

    assign scanMode = (mode == INIT) || (mode == CLEAR) || (mode == SCAN);
    assign scanBusy = (mode == DRAIN) || (mode == SCAN);
    assign scanDone = pfDone && (mode == SCAN);   // the reset pass reports nothing
    assign pfStart = (mode == INIT) || ((mode == DRAIN) && !s1Valid);

    // stage two, count seen by the increment
    assign curCount = fwdHit ? fwdData : hist.rdata;   // RAM data stale on a repeat
    assign incCount = (curCount == countMax) ? curCount : curCount + 1'b1;

    // pipeline control
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            s1Valid <= 1'b0;
            fwdHit <= 1'b0;
        end else begin
            s1Valid <= accept;
            // stage two writes the same bin that stage one reads now
            fwdHit <= accept && s1Valid && (s1Addr == sampleAddr);
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            s1Addr <= sampleAddr;
        end
        fwdData <= incCount;   // last written count, used only with fwdHit
    end

    // mode sequencing
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            mode <= INIT;
        end else begin
            case (mode)
                INIT: mode <= CLEAR;                     // launches the zeroing pass
                CLEAR: if (pfDone) mode <= ACCUM;
                ACCUM: if (closeFrame) mode <= DRAIN;
                DRAIN: if (!s1Valid) mode <= SCAN;       // last write has gone out
                SCAN: if (pfDone) mode <= ACCUM;
                default: mode <= INIT;
            endcase
        end
    end

    // hist port owner follows the mode
    always_comb begin
        if (scanMode) begin
            hist.raddr = scanRaddr;
            hist.rEnable = pfBusy;
            hist.waddr = scanWaddr;
            hist.wEnable = scanWen;
            hist.wdata = '0;          // scan leaves every bin empty
        end else begin
            hist.raddr = sampleAddr;
            hist.rEnable = accept;    // read in the accept cycle
            hist.waddr = s1Addr;
            hist.wEnable = s1Valid;   // write one cycle later
            hist.wdata = incCount;
        end
    end

    peakFinder peakFinder (
        .clk(clk),
        .rstN(rstN),
        .start(pfStart),
        .writeResults(mode == SCAN),   // no results from the reset pass
        .busy(pfBusy),
        .done(pfDone),
        .scanRaddr(scanRaddr),
        .scanRdata(hist.rdata),
        .scanWaddr(scanWaddr),
        .scanWen(scanWen),
        .peak(peak)
    );

endmodule

// ==== histogram/peakFinder.sv ====
module peakFinder import sifhPkg::*; (
    input  logic clk,
    input  logic rstN,
    input  logic start,
    input  logic writeResults,
    output logic busy,
    output logic done,
    output logic [addrBits-1:0] scanRaddr,
    input  countT scanRdata,
    output logic [addrBits-1:0] scanWaddr,
    output logic scanWen,
    histRamIf.fsmWr peak
);

    logic running;                  // reads still being issued
    logic [addrBits-1:0] rdAddr;
    logic rdValid;                  // scanRdata belongs to rdAddrQ
    logic [addrBits-1:0] rdAddrQ;
    logic [Nb-1:0] binQ;
    logic lastBin;
    peakT best;                     // running maximum of the current pixel
    peakT nextBest;

    assign scanRaddr = rdAddr;
    assign busy = running || rdValid;
    assign binQ = rdAddrQ[Nb-1:0];
    assign lastBin = (binQ == '1);
    assign done = rdValid && (rdAddrQ == '1);   // last bin of the last pixel

    // address walk, one read per cycle
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            running <= 1'b0;
            rdAddr <= '0;
            rdValid <= 1'b0;
            rdAddrQ <= '0;
        end else begin
            rdValid <= running;
            rdAddrQ <= rdAddr;
            if (start && !busy) begin
                running <= 1'b1;
                rdAddr <= '0;
            end else if (running) begin
                rdAddr <= rdAddr + 1'b1;
                if (rdAddr == '1) begin
                    running <= 1'b0;
                end
            end
        end
    end

    // strictly greater only, so a tie keeps the lower bin
    always_comb begin
        if ((binQ == '0) || (scanRdata > best.count)) begin
            nextBest.bin = binQ;          // bin 0 restarts the search
            nextBest.count = scanRdata;
        end else begin
            nextBest = best;
        end
    end

    always_ff @(posedge clk) begin
        if (rdValid) begin
            best <= nextBest;
        end
    end

    // clear each bin the cycle after it was read
    assign scanWaddr = rdAddrQ;
    assign scanWen = rdValid;

    // result write at each pixel's last bin
    assign peak.waddr = rdAddrQ[addrBits-1 -: pixBits];
    assign peak.wdata = nextBest;
    assign peak.wEnable = rdValid && lastBin && writeResults;

endmodule

// ==== histogram/histRam.sv ====
module histRam #(
    parameter type wordT = logic [7:0],
    parameter int depth = 256
) (
    input logic clk,
    histRamIf.ram ram
);

    // storage only, contents are cleared by a scan pass
    wordT mem [depth];

    // write port, lands at the clock edge
    always_ff @(posedge clk) begin
        if (ram.wEnable) begin
            mem[ram.waddr] <= ram.wdata;
        end
    end

    // read port, registered
    // same address as a concurrent write gives the old word
    always_ff @(posedge clk) begin
        if (ram.rEnable) begin
            ram.rdata <= mem[ram.raddr];   // holds while rEnable is low
        end
    end

endmodule

// ==== common/histRamIf.sv ====
// one write port and one read port of a simple dual-port RAM
interface histRamIf #(
    parameter int addrWidth = 8,
    parameter type wordT = logic [7:0]
);
    logic [addrWidth-1:0] waddr;   // write port
    logic [addrWidth-1:0] raddr;   // read port
    logic wEnable;
    logic rEnable;
    wordT wdata;
    wordT rdata;                   // valid one cycle after rEnable

    // controller side, both ports
    modport fsm (
        output waddr, raddr, wEnable, rEnable, wdata,
        input rdata
    );

    // controller side split in two, when writer and reader are different blocks
    modport fsmWr (output waddr, wEnable, wdata);
    modport fsmRd (output raddr, rEnable, input rdata);

    // memory side
    modport ram (
        input waddr, raddr, wEnable, rEnable, wdata,
        output rdata
    );

endinterface

// ==== common/axiLitePkg.sv ====
package axiLitePkg;

    localparam int axiAddrBits = 8;               // 256 byte register window
    localparam int axiDataBits = 32;
    localparam int axiStrbBits = axiDataBits / 8; // one strobe per byte lane

    // BRESP and RRESP codes
    localparam logic [1:0] RESP_OKAY = 2'b00;
    localparam logic [1:0] RESP_SLVERR = 2'b10;   // unmapped or read-only target

endpackage

// ==== common/sifhPkg.sv ====
package sifhPkg;

    // time code and histogram geometry
    localparam int Np = 10;                    // time code width
    localparam int Nb = 6;                     // bin index, top Nb bits of the code
    localparam int PIXEL_NUM_PER_RAM = 4;
    localparam int pixBits = 2;                // log2 of PIXEL_NUM_PER_RAM
    localparam int addrBits = pixBits + Nb;    // {pixel, bin}
    localparam int histDepth = 1 << addrBits;  // 256 bins in one RAM

    localparam int peakMax = 8;                // count width
    typedef logic [peakMax-1:0] countT;
    localparam countT countMax = '1;           // saturation level, 255

    // one word of the result RAM
    typedef struct packed {
        logic [Nb-1:0] bin;
        countT count;
    } peakT;

    // register map, byte offsets
    localparam logic [7:0] CTRL_OFFSET = 8'h00;    // bit0 closes the frame
    localparam logic [7:0] STATUS_OFFSET = 8'h04;
    localparam logic [7:0] PEAK_BASE = 8'h10;      // one word per pixel from here

    // STATUS bit positions
    localparam int STATUS_SCAN_BUSY = 0;
    localparam int STATUS_PEAKS_VALID = 1;

    // PEAK word layout
    localparam int PEAK_BIN_LSB = 16;    // bin in 21:16
    localparam int PEAK_COUNT_LSB = 0;   // count in 7:0

endpackage
